// File: Makefile
# Verilator build and run for the SPI I/O expander

VERILATOR  ?= verilator
TOP        := tb_spi_io_expander
FILELIST   := spi_io_expander.f
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := test passed

SOURCES := $(shell grep -v '^+' $(FILELIST)) spi_io_defines.svh

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The log decides the result, not the exit status of the binary
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cdc_synchron.sv
`timescale 1ns/1ps
`default_nettype none

module cdc_synchron (
    input  logic sysClk,
    input  logic rst_i,
    input  logic async_i,
    output logic sync_o,
    output logic rise_o,
    output logic fall_o
);

    // First stage, may go metastable
    logic meta_q;
    // Second stage, safe in the sysClk domain
    logic sync_q;
    // Previous synchronized level
    logic hist_q;

    // Chain keeps sampling during reset
    // so it settles on the pin level before release
    always_ff @(posedge sysClk) begin
        meta_q <= async_i;
        sync_q <= meta_q;
        hist_q <= sync_q;
    end

    // Edge pulses one cycle after sync_q changes
    always_ff @(posedge sysClk) begin
        if (rst_i) begin
            rise_o <= 1'b0;
            fall_o <= 1'b0;
        end else begin
            rise_o <= sync_q & ~hist_q;
            fall_o <= ~sync_q & hist_q;
        end
    end

    assign sync_o = sync_q;

endmodule

`default_nettype wire

// File: io_reg_file.sv
`timescale 1ns/1ps
`default_nettype none
`include "spi_io_defines.svh"

module io_reg_file (
    input  logic                  sysClk,
    input  logic                  rst_i,
    input  logic                  frame_start_i,
    input  spi_link_pkg::spi_rx_t rx_i,
    output io_reg_pkg::tx_load_t  tx_o,
    output spi_link_pkg::byte_t   gpio_o
);

    import spi_link_pkg::*;
    import io_reg_pkg::*;

    // Register storage
    byte_t regs_q [`SPI_IO_REG_COUNT];

    // Frame decoder state
    cmd_phase_t phase_q;
    logic       is_read_q;
    reg_addr_t  addr_q;

    // Read data towards the slave
    logic  tx_load_q;
    byte_t tx_data_q;

    // Address checks and read mux
    reg_addr_t rx_addr;
    logic      rx_addr_ok;
    logic      addr_ok;
    byte_t     rd_data;

    assign rx_addr    = rx_i.data;
    assign rx_addr_ok = rx_addr < 8'(`SPI_IO_REG_COUNT);
    assign addr_ok    = addr_q < 8'(`SPI_IO_REG_COUNT);

    // Out of range reads return 0
    always_comb begin
        rd_data = '0;
        if (rx_addr_ok) begin
            rd_data = regs_q[rx_addr[3:0]];
        end
    end

    // ------------------------------
    // Frame decoder
    // ------------------------------
    always_ff @(posedge sysClk) begin
        if (rst_i) begin
            // No frame yet, nothing to decode
            phase_q   <= PH_IGNORE;
            is_read_q <= 1'b0;
            tx_load_q <= 1'b0;
        end else begin
            tx_load_q <= 1'b0;
            if (frame_start_i) begin
                phase_q <= PH_OPCODE;
            end else if (rx_i.valid) begin
                case (phase_q)
                    PH_OPCODE: begin
                        if (rx_i.data == `SPI_IO_OP_WRITE) begin
                            is_read_q <= 1'b0;
                            phase_q   <= PH_ADDR;
                        end else if (rx_i.data == `SPI_IO_OP_READ) begin
                            is_read_q <= 1'b1;
                            phase_q   <= PH_ADDR;
                        end else begin
                            // Unknown opcode, rest of frame is dropped
                            phase_q <= PH_IGNORE;
                        end
                    end
                    PH_ADDR: begin
                        // Read data goes out during the next byte
                        tx_load_q <= is_read_q;
                        phase_q   <= PH_DATA;
                    end
                    PH_DATA: begin
                        phase_q <= PH_DONE;
                    end
                    default: begin
                        // PH_DONE and PH_IGNORE hold until the next frame
                    end
                endcase
            end
        end
    end

    // Address and read data captured on the address byte
    always_ff @(posedge sysClk) begin
        if (rx_i.valid && (phase_q == PH_ADDR)) begin
            addr_q    <= rx_addr;
            tx_data_q <= rd_data;
        end
    end

    assign tx_o.load = tx_load_q;
    assign tx_o.data = tx_data_q;

    // ------------------------------
    // Registers and GPIO
    // ------------------------------
    always_ff @(posedge sysClk) begin
        if (rst_i) begin
            for (int i = 0; i < `SPI_IO_REG_COUNT; i++) begin
                regs_q[i] <= `SPI_IO_REG_RESET;
            end
            regs_q[`SPI_IO_ADDR_DIR] <= `SPI_IO_DIR_RESET;
        end else if (rx_i.valid && (phase_q == PH_DATA) && !is_read_q && addr_ok) begin
            regs_q[addr_q[3:0]] <= rx_i.data;
        end
    end

    // Direction bit 1 means input, pin shows 0
    assign gpio_o = regs_q[`SPI_IO_ADDR_OLAT] & ~regs_q[`SPI_IO_ADDR_DIR];

endmodule

`default_nettype wire

// File: io_reg_pkg.sv
`default_nettype none

package io_reg_pkg;

    // Full byte so out-of-range addresses stay visible
    typedef logic [7:0] reg_addr_t;

    // Position of the decoder within a frame
    typedef enum logic [2:0] {
        PH_OPCODE,
        PH_ADDR,
        PH_DATA,
        PH_DONE,
        PH_IGNORE
    } cmd_phase_t;

    // Byte handed to the slave for shifting out
    typedef struct packed {
        logic                load;
        spi_link_pkg::byte_t data;
    } tx_load_t;

endpackage

`default_nettype wire

// File: spi_io_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "spi_io_defines.svh"

module spi_io_checker (
    input logic sysClk,
    input logic rst_i,
    input logic sclk_i,
    input logic cs_n_sync_i,
    input logic cs_n_rise_i,
    input logic tx_bit_i,
    input logic rx_valid_i,
    input logic tx_load_i
);

    // Saturating count of cycles the current sclk level has been held
    logic [3:0] hold_cnt_q;
    logic       sclk_prev_q;
    logic       sclk_changed;

    // Number of property failures so far
    int unsigned fail_cnt = 0;

    assign sclk_changed = sclk_i != sclk_prev_q;

    always_ff @(posedge sysClk) begin
        sclk_prev_q <= sclk_i;
        if (rst_i) begin
            hold_cnt_q <= 4'(`SPI_IO_MIN_HALF_CYCLES);
        end else if (sclk_changed) begin
            hold_cnt_q <= 4'd1;
        end else if (hold_cnt_q != 4'hF) begin
            hold_cnt_q <= hold_cnt_q + 4'd1;
        end
    end

    // ------------------------------
    // Properties
    // ------------------------------
    // Transmit bit drained once the end of frame has been taken
    a_miso_idle: assert property (@(posedge sysClk) disable iff (rst_i)
        (cs_n_sync_i && $past(cs_n_sync_i) && !cs_n_rise_i) |-> !tx_bit_i)
        else begin
            fail_cnt++;
            $error("miso shift register still holds data after the frame ended");
        end

    // Strobes are single cycle
    a_rx_pulse: assert property (@(posedge sysClk) disable iff (rst_i)
        rx_valid_i |=> !rx_valid_i)
        else begin
            fail_cnt++;
            $error("rx.valid held for two cycles");
        end

    a_tx_pulse: assert property (@(posedge sysClk) disable iff (rst_i)
        tx_load_i |=> !tx_load_i)
        else begin
            fail_cnt++;
            $error("tx.load held for two cycles");
        end

    // Read data only loads inside a frame
    a_tx_in_frame: assert property (@(posedge sysClk) disable iff (rst_i)
        tx_load_i |-> !cs_n_sync_i)
        else begin
            fail_cnt++;
            $error("tx.load outside a frame");
        end

    // Master respects the shortest sclk level
    a_sclk_hold: assert property (@(posedge sysClk) disable iff (rst_i)
        sclk_changed |-> (hold_cnt_q >= 4'(`SPI_IO_MIN_HALF_CYCLES)))
        else begin
            fail_cnt++;
            $error("sclk level held for fewer cycles than the synchronizers need");
        end

endmodule

bind spi_io_expander spi_io_checker u_checker (
    .sysClk     (sysClk),
    .rst_i      (rst_i),
    .sclk_i     (sclk_i),
    .cs_n_sync_i(cs_n_sync),
    .cs_n_rise_i(cs_n_rise),
    .tx_bit_i   (u_slave.miso_q),
    .rx_valid_i (rx.valid),
    .tx_load_i  (tx.load)
);

`default_nettype wire

// File: spi_io_defines.svh
`ifndef SPI_IO_DEFINES_SVH
`define SPI_IO_DEFINES_SVH

// ------------------------------
// Command opcodes
// ------------------------------
`define SPI_IO_OP_WRITE 8'h40
`define SPI_IO_OP_READ 8'h41

// ------------------------------
// Register map
// ------------------------------
`define SPI_IO_REG_COUNT 11
`define SPI_IO_ADDR_DIR 0
`define SPI_IO_ADDR_OLAT 10

// Reset values, direction defaults to all inputs
`define SPI_IO_DIR_RESET 8'hFF
`define SPI_IO_REG_RESET 8'h00

// Shortest sclk level the synchronizer path can follow
`define SPI_IO_MIN_HALF_CYCLES 6

`endif

// File: spi_io_expander.f
+incdir+.
spi_link_pkg.sv
io_reg_pkg.sv
cdc_synchron.sv
spi_slave.sv
io_reg_file.sv
spi_io_expander.sv
spi_io_checker.sv
tb_spi_io_expander.sv

// File: spi_io_expander.sv
`timescale 1ns/1ps
`default_nettype none

module spi_io_expander (
    input  logic                sysClk,
    input  logic                rst_i,
    input  logic                sclk_i,
    input  logic                mosi_i,
    input  logic                cs_n_i,
    output logic                miso_o,
    output spi_link_pkg::byte_t gpio_o
);

    import spi_link_pkg::*;
    import io_reg_pkg::*;

    // Synchronized pins and their edges
    logic sclk_rise;
    logic sclk_fall;
    logic mosi_sync;
    logic cs_n_sync;
    logic cs_n_rise;
    logic cs_n_fall;

    // Slave to decoder and back
    logic     frame_start;
    spi_rx_t  rx;
    tx_load_t tx;

    // ------------------------------
    // Pin synchronizers
    // ------------------------------
    // Only edges are needed from sclk
    cdc_synchron u_sclk_sync (
        .sysClk (sysClk),
        .rst_i  (rst_i),
        .async_i(sclk_i),
        .sync_o (),
        .rise_o (sclk_rise),
        .fall_o (sclk_fall)
    );

    // Only the level is needed from mosi
    cdc_synchron u_mosi_sync (
        .sysClk (sysClk),
        .rst_i  (rst_i),
        .async_i(mosi_i),
        .sync_o (mosi_sync),
        .rise_o (),
        .fall_o ()
    );

    // cs_n idles high, chain seeds from the pin in reset
    cdc_synchron u_cs_n_sync (
        .sysClk (sysClk),
        .rst_i  (rst_i),
        .async_i(cs_n_i),
        .sync_o (cs_n_sync),
        .rise_o (cs_n_rise),
        .fall_o (cs_n_fall)
    );

    // ------------------------------
    // Shift engine and registers
    // ------------------------------
    spi_slave u_slave (
        .sysClk       (sysClk),
        .rst_i        (rst_i),
        .sclk_rise_i  (sclk_rise),
        .sclk_fall_i  (sclk_fall),
        .mosi_i       (mosi_sync),
        .cs_n_i       (cs_n_sync),
        .cs_n_rise_i  (cs_n_rise),
        .cs_n_fall_i  (cs_n_fall),
        .tx_i         (tx),
        .rx_o         (rx),
        .frame_start_o(frame_start),
        .miso_o       (miso_o)
    );

    io_reg_file u_reg_file (
        .sysClk       (sysClk),
        .rst_i        (rst_i),
        .frame_start_i(frame_start),
        .rx_i         (rx),
        .tx_o         (tx),
        .gpio_o       (gpio_o)
    );

endmodule

`default_nettype wire

// File: spi_link_pkg.sv
`default_nettype none

package spi_link_pkg;

    // One byte as it travels on MOSI or MISO
    typedef logic [7:0] byte_t;

    // Position of the current bit within a byte
    typedef logic [2:0] bit_cnt_t;

    // Slave framing state
    // SL_IDLE while chip select is high
    typedef enum logic {
        SL_IDLE,
        SL_SHIFTING
    } slave_state_t;

    // Received byte with a one-cycle strobe
    typedef struct packed {
        logic  valid;
        byte_t data;
    } spi_rx_t;

endpackage

`default_nettype wire

// File: spi_slave.sv
`timescale 1ns/1ps
`default_nettype none

module spi_slave (
    input  logic                  sysClk,
    input  logic                  rst_i,
    input  logic                  sclk_rise_i,
    input  logic                  sclk_fall_i,
    input  logic                  mosi_i,
    input  logic                  cs_n_i,
    input  logic                  cs_n_rise_i,
    input  logic                  cs_n_fall_i,
    input  io_reg_pkg::tx_load_t  tx_i,
    output spi_link_pkg::spi_rx_t rx_o,
    output logic                  frame_start_o,
    output logic                  miso_o
);

    import spi_link_pkg::*;

    // Framing state and bit position
    slave_state_t state_q;
    bit_cnt_t     bit_cnt_q;

    // Receive path
    byte_t rx_sr_q;
    byte_t rx_data_q;
    logic  rx_valid_q;

    // Transmit path
    byte_t tx_sr_q;
    logic  miso_q;

    // Qualified clock edges, only inside a frame
    logic shift_in;
    logic shift_out;
    logic byte_done;

    assign shift_in  = (state_q == SL_SHIFTING) && sclk_rise_i;
    assign shift_out = (state_q == SL_SHIFTING) && sclk_fall_i;
    // Eighth rise of the current byte
    assign byte_done = shift_in && (bit_cnt_q == 3'd7);

    // ------------------------------
    // Framing
    // ------------------------------
    always_ff @(posedge sysClk) begin
        if (rst_i) begin
            state_q   <= SL_IDLE;
            bit_cnt_q <= '0;
        end else if (cs_n_rise_i) begin
            // End of frame, drop any partial byte
            state_q   <= SL_IDLE;
            bit_cnt_q <= '0;
        end else if (cs_n_fall_i) begin
            state_q   <= SL_SHIFTING;
            bit_cnt_q <= '0;
        end else if (shift_in) begin
            // Wraps to 0 after the last bit
            bit_cnt_q <= bit_cnt_q + 3'd1;
        end
    end

    // Frame start strobe for the decoder
    always_ff @(posedge sysClk) begin
        if (rst_i) begin
            frame_start_o <= 1'b0;
        end else begin
            frame_start_o <= cs_n_fall_i;
        end
    end

    // ------------------------------
    // Receive, MSB first
    // ------------------------------
    always_ff @(posedge sysClk) begin
        if (shift_in) begin
            rx_sr_q <= {rx_sr_q[6:0], mosi_i};
        end
        // Capture including the bit arriving now
        if (byte_done) begin
            rx_data_q <= {rx_sr_q[6:0], mosi_i};
        end
    end

    always_ff @(posedge sysClk) begin
        if (rst_i) begin
            rx_valid_q <= 1'b0;
        end else begin
            rx_valid_q <= byte_done;
        end
    end

    assign rx_o.valid = rx_valid_q;
    assign rx_o.data  = rx_data_q;

    // ------------------------------
    // Transmit, mode 0
    // ------------------------------
    // Load puts bit 7 out at once and keeps the whole byte
    // The boundary fall re-presents bit 7, later falls walk down
    // Zeros fill in behind, so unread bytes shift out 0
    always_ff @(posedge sysClk) begin
        if (rst_i) begin
            tx_sr_q <= '0;
            miso_q  <= 1'b0;
        end else if (cs_n_rise_i || cs_n_fall_i) begin
            tx_sr_q <= '0;
            miso_q  <= 1'b0;
        end else if (tx_i.load) begin
            tx_sr_q <= tx_i.data;
            miso_q  <= tx_i.data[7];
        end else if (shift_out) begin
            miso_q  <= tx_sr_q[7];
            tx_sr_q <= {tx_sr_q[6:0], 1'b0};
        end
    end

    // Pin held low as soon as chip select is seen high
    assign miso_o = miso_q & ~cs_n_i;

endmodule

`default_nettype wire

// File: tb_spi_io_expander.sv
`timescale 1ns/1ps
`default_nettype none
`include "spi_io_defines.svh"

module tb_spi_io_expander;

    import spi_link_pkg::*;

    // Upper bound on frames in the run
    localparam int FRAME_COUNT    = 128;
    localparam int TIMEOUT_CYCLES = FRAME_COUNT * 3 * 8 * 20 + FRAME_COUNT * 64 + 4000;

    // DUT pins start at their idle levels
    logic  sysClk = 1'b0;
    logic  rst_i  = 1'b1;
    logic  sclk   = 1'b0;
    logic  mosi   = 1'b0;
    logic  cs_n   = 1'b1;
    logic  miso;
    byte_t gpio;

    // Register model
    byte_t model_regs [`SPI_IO_REG_COUNT];

    // Bytes sent and seen on MISO in the current frame
    byte_t mosi_bytes [5];
    byte_t miso_bytes [5];
    byte_t miso_expect [5];

    int half_cycles = `SPI_IO_MIN_HALF_CYCLES;
    int err_cnt     = 0;
    int check_cnt   = 0;
    int cycle_cnt   = 0;

    spi_io_expander dut_i (
        .sysClk(sysClk),
        .rst_i (rst_i),
        .sclk_i(sclk),
        .mosi_i(mosi),
        .cs_n_i(cs_n),
        .miso_o(miso),
        .gpio_o(gpio)
    );

    always #2 sysClk = ~sysClk;

    // Hard stop if the run stalls
    always @(posedge sysClk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    // Land 1 ns after the n-th rising edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sysClk);
        #1;
    endtask

    task automatic check_byte(input string name, input byte_t got, input byte_t exp);
        check_cnt++;
        assert (got === exp) else begin
            err_cnt++;
            $display("mismatch at %0t ns: %s got %02h expected %02h", $time, name, got, exp);
        end
    endtask

    // ------------------------------
    // Mode 0 master
    // ------------------------------
    task automatic spi_transfer(input int nbytes);
        byte_t out_sr;
        cs_n = 1'b0;
        wait_cycles(half_cycles);
        for (int b = 0; b < nbytes; b++) begin
            out_sr        = mosi_bytes[b];
            miso_bytes[b] = 8'h00;
            repeat (8) begin
                // MSB first with data set up while sclk is low
                mosi   = out_sr[7];
                out_sr = {out_sr[6:0], 1'b0};
                wait_cycles(half_cycles);
                // Sample just ahead of the rising edge
                miso_bytes[b] = {miso_bytes[b][6:0], miso};
                sclk = 1'b1;
                wait_cycles(half_cycles);
                sclk = 1'b0;
            end
        end
        wait_cycles(half_cycles);
        cs_n = 1'b1;
        mosi = 1'b0;
        // Frame end has to clear the synchronizers
        wait_cycles(half_cycles);
    endtask

    // Predict MISO and run the frame before updating the model
    task automatic run_frame(input int nbytes);
        byte_t op;
        byte_t addr;
        logic  in_range;
        byte_t exp_gpio;
        op          = mosi_bytes[0];
        addr        = mosi_bytes[1];
        in_range    = int'(addr) < `SPI_IO_REG_COUNT;
        half_cycles = `SPI_IO_MIN_HALF_CYCLES + int'($urandom % 5);
        for (int b = 0; b < 5; b++) begin
            miso_expect[b] = 8'h00;
        end
        // Only the third byte of a read carries data
        if (op == `SPI_IO_OP_READ && in_range) begin
            miso_expect[2] = model_regs[addr[3:0]];
        end
        spi_transfer(nbytes);
        for (int b = 0; b < nbytes; b++) begin
            check_byte("miso_o", miso_bytes[b], miso_expect[b]);
        end
        if (op == `SPI_IO_OP_WRITE && in_range && nbytes >= 3) begin
            model_regs[addr[3:0]] = mosi_bytes[2];
        end
        // Pin shows latch bit where direction is output
        exp_gpio = model_regs[`SPI_IO_ADDR_OLAT] & ~model_regs[`SPI_IO_ADDR_DIR];
        check_byte("gpio_o", gpio, exp_gpio);
    endtask

    task automatic write_reg(input byte_t addr, input byte_t data);
        mosi_bytes[0] = `SPI_IO_OP_WRITE;
        mosi_bytes[1] = addr;
        mosi_bytes[2] = data;
        run_frame(3);
    endtask

    // Master clocks a random dummy byte during the data phase
    task automatic read_reg(input byte_t addr);
        mosi_bytes[0] = `SPI_IO_OP_READ;
        mosi_bytes[1] = addr;
        mosi_bytes[2] = 8'($urandom);
        run_frame(3);
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------
    initial begin
        byte_t       op;
        int unsigned prop_fail_cnt;
        void'($urandom(32'h5cf0));
        for (int i = 0; i < `SPI_IO_REG_COUNT; i++) begin
            model_regs[i] = 8'h00;
        end
        model_regs[`SPI_IO_ADDR_DIR] = `SPI_IO_DIR_RESET;
        wait_cycles(16);
        rst_i = 1'b0;
        wait_cycles(4);

        // Reset values with every pin an input
        check_byte("gpio_o", gpio, 8'h00);
        for (int a = 0; a < `SPI_IO_REG_COUNT; a++) begin
            read_reg(8'(a));
        end

        // Random writes each followed by a random read
        repeat (40) begin
            write_reg(8'($urandom % 11), 8'($urandom));
            read_reg(8'($urandom % 11));
        end

        // Addresses past the register file
        repeat (3) begin
            write_reg(8'(11 + $urandom % 245), 8'($urandom));
            read_reg(8'(11 + $urandom % 245));
        end

        // Unknown opcodes
        repeat (4) begin
            op = 8'($urandom);
            if (op == `SPI_IO_OP_WRITE || op == `SPI_IO_OP_READ) begin
                op = op ^ 8'h80;
            end
            mosi_bytes[0] = op;
            mosi_bytes[1] = 8'($urandom % 11);
            mosi_bytes[2] = 8'($urandom);
            run_frame(3);
        end

        // Direction and latch writes with gpio checked after each frame
        repeat (3) begin
            write_reg(8'(`SPI_IO_ADDR_DIR), 8'($urandom));
            write_reg(8'(`SPI_IO_ADDR_OLAT), 8'($urandom));
        end

        // Two trailing bytes per frame
        repeat (4) begin
            op = ($urandom % 2 == 0) ? `SPI_IO_OP_READ : `SPI_IO_OP_WRITE;
            mosi_bytes[0] = op;
            mosi_bytes[1] = 8'($urandom % 11);
            mosi_bytes[2] = 8'($urandom);
            mosi_bytes[3] = 8'($urandom);
            mosi_bytes[4] = 8'($urandom);
            run_frame(5);
        end

        // Final sweep confirms nothing else moved
        for (int a = 0; a < `SPI_IO_REG_COUNT; a++) begin
            read_reg(8'(a));
        end

        prop_fail_cnt = dut_i.u_checker.fail_cnt;
        $display("checks %0d, errors %0d, property failures %0d",
                 check_cnt, err_cnt, prop_fail_cnt);
        if (err_cnt == 0 && prop_fail_cnt == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
